// ==== design/prefetch_pkg.sv ====
package prefetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int addr_w     = 32;
  // words per memory line, the aligner index logic assumes four
  localparam int line_words = 4;
  // byte offset bits inside one line
  localparam int line_off_w = 4;

  // byte address
  typedef logic [addr_w-1:0] addr_t;
  // full instruction word
  typedef logic [31:0]       word_t;
  // one instruction parcel
  typedef logic [15:0]       half_t;
  // one memory line, word 0 in the low bits
  typedef word_t [line_words-1:0] line_t;

  //////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////

  // fetcher to instruction memory, addr is always line aligned
  typedef struct packed {
    logic  req;
    addr_t addr;
  } mem_req_t;

  // instruction memory to fetcher
  typedef struct packed {
    logic  rvalid;
    line_t rdata;
  } mem_rsp_t;

  // one queued line on its way to the aligner
  typedef struct packed {
    addr_t line_addr;
    line_t data;
  } line_pkt_t;

  // instruction handed to the core
  typedef struct packed {
    addr_t addr;
    word_t rdata;
  } instr_pkt_t;

  // memory side fsm of the line fetcher
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    WAIT_GNT
  } fetch_state_e;

endpackage

// ==== design/line_fetcher.sv ====
`timescale 1ns/100ps

module line_fetcher (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  prefetch_pkg::addr_t     flush_addr_i,
  output prefetch_pkg::mem_req_t  mem_req_o,
  input  logic                    gnt_i,
  input  prefetch_pkg::mem_rsp_t  mem_rsp_i,
  output prefetch_pkg::line_pkt_t line_o,
  output logic                    line_valid_o,
  input  logic                    line_ready_i
);

  prefetch_pkg::fetch_state_e state_q, state_d;

  // next line to request, and the one held while waiting for grant
  prefetch_pkg::addr_t next_addr_q;
  prefetch_pkg::addr_t wait_addr_q;
  // address of the granted line whose response is still pending
  prefetch_pkg::addr_t rsp_addr_q;
  prefetch_pkg::addr_t flush_line;

  logic wait_stale_q;
  logic out_q;
  logic stale_q;

  // two entry line queue
  prefetch_pkg::line_pkt_t queue_q [2];
  logic                    wr_ptr_q;
  logic                    rd_ptr_q;
  logic [1:0]              count_q;
  logic [1:0]              occupancy;

  logic issue;
  logic granted;
  logic push;
  logic pop;

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  assign flush_line = {flush_addr_i[prefetch_pkg::addr_w-1:prefetch_pkg::line_off_w],
                       {prefetch_pkg::line_off_w{1'b0}}};

  // lines in the queue plus the one still in flight
  assign occupancy = count_q + {1'b0, out_q};

  // a response arriving this cycle frees the single outstanding slot
  assign issue = (state_q == prefetch_pkg::FETCH) && !flush_i &&
                 (!out_q || mem_rsp_i.rvalid) && (occupancy < 2'd2);

  always_comb begin
    mem_req_o.req  = issue || (state_q == prefetch_pkg::WAIT_GNT);
    mem_req_o.addr = (state_q == prefetch_pkg::WAIT_GNT) ? wait_addr_q : next_addr_q;
  end

  assign granted = mem_req_o.req && gnt_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      prefetch_pkg::IDLE: begin
        // nothing to fetch until the first start address
        if (flush_i) begin
          state_d = prefetch_pkg::FETCH;
        end
      end
      prefetch_pkg::FETCH: begin
        if (issue && !gnt_i) begin
          state_d = prefetch_pkg::WAIT_GNT;
        end
      end
      prefetch_pkg::WAIT_GNT: begin
        if (gnt_i) begin
          state_d = prefetch_pkg::FETCH;
        end
      end
      default: begin
        state_d = prefetch_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= prefetch_pkg::IDLE;
      next_addr_q  <= '0;
      wait_stale_q <= 1'b0;
      out_q        <= 1'b0;
      stale_q      <= 1'b0;
    end else begin
      state_q <= state_d;

      if (flush_i) begin
        next_addr_q <= flush_line;
      end else if (granted && !(state_q == prefetch_pkg::WAIT_GNT && wait_stale_q)) begin
        next_addr_q <= next_addr_q +
                       prefetch_pkg::addr_t'(prefetch_pkg::line_words * 4);
      end

      // the request waiting for grant was overtaken by a flush
      wait_stale_q <= (state_q == prefetch_pkg::WAIT_GNT) && !gnt_i &&
                      (wait_stale_q || flush_i);

      if (granted) begin
        out_q <= 1'b1;
      end else if (mem_rsp_i.rvalid) begin
        out_q <= 1'b0;
      end

      if (granted) begin
        stale_q <= flush_i || (state_q == prefetch_pkg::WAIT_GNT && wait_stale_q);
      end else if (mem_rsp_i.rvalid) begin
        stale_q <= 1'b0;
      end else if (flush_i && out_q) begin
        stale_q <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // line queue
  //////////////////////////////////////////////////////////////////////

  // stale or flushed responses never enter
  assign push = mem_rsp_i.rvalid && !stale_q && !flush_i;
  assign pop  = line_valid_o && line_ready_i;

  assign line_valid_o = (count_q != 2'd0) && !flush_i;
  assign line_o       = queue_q[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else if (flush_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      wait_addr_q <= next_addr_q;
    end
    if (granted) begin
      rsp_addr_q <= mem_req_o.addr;
    end
    if (push) begin
      queue_q[wr_ptr_q].line_addr <= rsp_addr_q;
      queue_q[wr_ptr_q].data      <= mem_rsp_i.rdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o.req && !gnt_i |=> mem_req_o.req && $stable(mem_req_o.addr))
    else $error("memory request dropped or changed before grant");

  rvalid_out_a: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rsp_i.rvalid |-> out_q)
    else $error("response without an outstanding request");

  queue_full_a: assert property (@(posedge clk) disable iff (!rst_n)
    push && !pop |-> count_q < 2'd2)
    else $error("line queue overflow");

endmodule

// ==== design/instr_aligner.sv ====
`timescale 1ns/100ps

module instr_aligner (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,
  input  prefetch_pkg::addr_t      flush_addr_i,
  input  prefetch_pkg::line_pkt_t  line_i,
  input  logic                     line_valid_i,
  output logic                     line_ready_o,
  output prefetch_pkg::instr_pkt_t instr_o,
  output logic                     valid_o,
  input  logic                     ready_i
);

  // halfword address of the next instruction to build
  prefetch_pkg::addr_t pc_q;
  prefetch_pkg::addr_t next_pc;
  prefetch_pkg::addr_t step;

  // lower half of a 32-bit instruction that crosses into the next line
  prefetch_pkg::half_t save_q;
  logic                pending_q;

  prefetch_pkg::instr_pkt_t instr_q;
  prefetch_pkg::instr_pkt_t instr_d;
  logic                     valid_q;

  // line viewed as parcels
  prefetch_pkg::half_t [2*prefetch_pkg::line_words-1:0] halves;
  logic [prefetch_pkg::line_off_w-2:0]                  hw_idx;
  logic [prefetch_pkg::line_off_w-2:0]                  hw_nxt;
  prefetch_pkg::half_t                                  hw_lo;
  prefetch_pkg::half_t                                  hw_hi;

  logic lo_compressed;
  logic last_half;
  logic can_build;
  logic load;
  logic save;
  logic leaves_line;

  //////////////////////////////////////////////////////////////////////
  // parcel selection
  //////////////////////////////////////////////////////////////////////

  assign halves = line_i.data;
  assign hw_idx = pc_q[prefetch_pkg::line_off_w-1:1];
  // wraps to parcel 0 in the last slot, only used when compressed there
  assign hw_nxt = hw_idx + 1'b1;
  assign hw_lo  = halves[hw_idx];
  assign hw_hi  = halves[hw_nxt];

  // the saved half of a crossing instruction is never compressed
  assign lo_compressed = pending_q ? 1'b0 : (hw_lo[1:0] != 2'b11);
  assign last_half     = (hw_idx == '1);

  // a full 32-bit instruction starting in the last parcel has to wait
  assign can_build = line_valid_i && (pending_q || !(last_half && !lo_compressed));

  // output slot is free or being emptied this cycle
  assign load = can_build && (!valid_q || ready_i) && !flush_i;

  // keep the lower half and move on to the next line
  assign save = line_valid_i && !pending_q && last_half && !lo_compressed && !flush_i;

  always_comb begin
    instr_d.addr = pc_q;
    if (pending_q) begin
      instr_d.rdata = {halves[0], save_q};
    end else begin
      instr_d.rdata = {hw_hi, hw_lo};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // address advance and line pop
  //////////////////////////////////////////////////////////////////////

  assign step    = lo_compressed ? prefetch_pkg::addr_t'(2) : prefetch_pkg::addr_t'(4);
  assign next_pc = pc_q + step;

  assign leaves_line =
    next_pc[prefetch_pkg::addr_w-1:prefetch_pkg::line_off_w] !=
    pc_q[prefetch_pkg::addr_w-1:prefetch_pkg::line_off_w];

  // after a crossing the pc still points into the old line
  // so that case must not pop the new one
  assign line_ready_o = (load && !pending_q && leaves_line) || save;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q      <= '0;
      pending_q <= 1'b0;
      valid_q   <= 1'b0;
    end else if (flush_i) begin
      pc_q      <= {flush_addr_i[prefetch_pkg::addr_w-1:1], 1'b0};
      pending_q <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      if (load) begin
        pc_q      <= next_pc;
        pending_q <= 1'b0;
      end else if (save) begin
        pending_q <= 1'b1;
      end

      if (load) begin
        valid_q <= 1'b1;
      end else if (ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (save) begin
      save_q <= hw_lo;
    end
    if (load) begin
      instr_q <= instr_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // core side
  //////////////////////////////////////////////////////////////////////

  assign instr_o = instr_q;
  assign valid_o = valid_q && !flush_i;

  // stalled output holds until taken or flushed
  out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=> $stable(instr_o) && (valid_o || flush_i))
    else $error("output changed under back-pressure");

  // line in front belongs to the current parcel or follows it during a crossing
  line_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
    line_valid_i |-> line_i.line_addr[prefetch_pkg::addr_w-1:prefetch_pkg::line_off_w] ==
                     pc_q[prefetch_pkg::addr_w-1:prefetch_pkg::line_off_w] + pending_q)
    else $error("line address does not match the fetch position");

endmodule

// ==== design/prefetch_buffer.sv ====
`timescale 1ns/100ps

module prefetch_buffer (
  input  logic                     clk,
  input  logic                     rst_n,

  // restart from a new halfword address
  input  logic                     branch_i,
  input  prefetch_pkg::addr_t      branch_addr_i,

  // instruction memory
  output prefetch_pkg::mem_req_t   mem_req_o,
  input  logic                     gnt_i,
  input  prefetch_pkg::mem_rsp_t   mem_rsp_i,

  // core
  output prefetch_pkg::instr_pkt_t instr_o,
  output logic                     valid_o,
  input  logic                     ready_i
);

  prefetch_pkg::line_pkt_t line;
  logic                    line_valid;
  logic                    line_ready;

  // memory side, up to two lines ahead
  line_fetcher i_fetcher (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (branch_i),
    .flush_addr_i (branch_addr_i),
    .mem_req_o    (mem_req_o),
    .gnt_i        (gnt_i),
    .mem_rsp_i    (mem_rsp_i),
    .line_o       (line),
    .line_valid_o (line_valid),
    .line_ready_i (line_ready)
  );

  // core side, one instruction per transfer
  instr_aligner i_aligner (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (branch_i),
    .flush_addr_i (branch_addr_i),
    .line_i       (line),
    .line_valid_i (line_valid),
    .line_ready_o (line_ready),
    .instr_o      (instr_o),
    .valid_o      (valid_o),
    .ready_i      (ready_i)
  );

endmodule

// ==== bench/imem_model.sv ====
`timescale 1ns/100ps

module imem_model #(
  parameter int depth         = 256,
  parameter int max_gnt_delay = 3,
  parameter int max_rsp_delay = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  prefetch_pkg::mem_req_t mem_req_i,
  output logic                   gnt_o,
  output prefetch_pkg::mem_rsp_t mem_rsp_o
);

  prefetch_pkg::line_t lines [depth];

  // granted lines in order, with the cycle each one is due
  prefetch_pkg::line_t rsp_data [$];
  longint              rsp_due  [$];

  longint cycle     = 0;
  longint last_due  = 0;
  longint due;
  int     gnt_delay = 0;
  int     wait_cnt  = 0;

  // random words, every parcel gets its own value
  task automatic fill_random();
    for (int i = 0; i < depth; i++) begin
      for (int w = 0; w < prefetch_pkg::line_words; w++) begin
        lines[i][w] = $urandom();
      end
    end
  endtask

  initial begin
    gnt_o     = 1'b0;
    mem_rsp_o = '0;
  end

  // bookkeeping on the edge where the fetcher samples
  always @(posedge clk) begin
    if (!rst_n) begin
      rsp_data.delete();
      rsp_due.delete();
      wait_cnt = 0;
    end else begin
      cycle++;
      if (mem_rsp_o.rvalid) begin
        void'(rsp_data.pop_front());
        void'(rsp_due.pop_front());
      end
      if (mem_req_i.req && gnt_o) begin
        // keep responses in order
        due = cycle + longint'($urandom_range(1, max_rsp_delay));
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_data.push_back(lines[(mem_req_i.addr >> prefetch_pkg::line_off_w) % depth]);
        rsp_due.push_back(due);
        gnt_delay = $urandom_range(0, max_gnt_delay);
        wait_cnt  = 0;
      end else if (mem_req_i.req) begin
        wait_cnt++;
      end
    end
  end

  // gnt may already be up when req rises, which gives a zero cycle grant
  always @(negedge clk) begin
    if (!rst_n) begin
      gnt_o     = 1'b0;
      mem_rsp_o = '0;
    end else begin
      gnt_o            = (wait_cnt >= gnt_delay);
      mem_rsp_o.rvalid = (rsp_due.size() != 0) && (rsp_due[0] <= cycle + 1);
      mem_rsp_o.rdata  = mem_rsp_o.rvalid ? rsp_data[0] : '0;
    end
  end

endmodule

// ==== bench/prefetch_tb.sv ====
`timescale 1ns/100ps

module prefetch_tb;

  localparam int mem_lines     = 256;
  localparam int max_gnt_delay = 3;
  localparam int max_rsp_delay = 4;
  localparam int seq_instr     = 500;
  localparam int total_instr   = 3000;
  // cycles without an accepted instruction before giving up
  localparam int max_idle      = 300;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     branch;
  prefetch_pkg::addr_t      branch_addr;
  logic                     ready;
  logic                     gnt;
  prefetch_pkg::mem_req_t   mem_req;
  prefetch_pkg::mem_rsp_t   mem_rsp;
  prefetch_pkg::instr_pkt_t instr;
  logic                     valid;

  // reference stream
  prefetch_pkg::addr_t exp_addr;
  logic   started      = 1'b0;
  logic   wait_first   = 1'b0;
  longint cycle        = 0;
  longint branch_cycle = 0;
  int     accepted     = 0;
  int     crossings    = 0;
  int     flushed_busy = 0;

  // memory port and back-pressure monitor
  logic                     req_waiting  = 1'b0;
  prefetch_pkg::addr_t      req_addr;
  int                       outstanding  = 0;
  logic                     hold_pending = 1'b0;
  prefetch_pkg::instr_pkt_t hold_pkt;
  logic                     req_expected = 1'b0;
  prefetch_pkg::addr_t      req_line;

  always #2 clk = ~clk;

  prefetch_buffer dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .mem_req_o     (mem_req),
    .gnt_i         (gnt),
    .mem_rsp_i     (mem_rsp),
    .instr_o       (instr),
    .valid_o       (valid),
    .ready_i       (ready)
  );

  imem_model #(
    .depth         (mem_lines),
    .max_gnt_delay (max_gnt_delay),
    .max_rsp_delay (max_rsp_delay)
  ) imem (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req_i (mem_req),
    .gnt_o     (gnt),
    .mem_rsp_o (mem_rsp)
  );

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      stop_with_failure();
    end
  endtask

  function automatic prefetch_pkg::half_t parcel_at(input prefetch_pkg::addr_t addr);
    logic [127:0] flat;
    flat = imem.lines[(addr >> prefetch_pkg::line_off_w) % mem_lines];
    return flat[16*addr[3:1] +: 16];
  endfunction

  function automatic prefetch_pkg::addr_t random_addr();
    return $urandom() & ~32'h1;
  endfunction

  task automatic score_instr();
    prefetch_pkg::half_t lo;
    lo = parcel_at(exp_addr);
    check_equal(started, 1'b1, "instruction accepted before any branch");
    check_equal(instr.addr, exp_addr, "instruction address");
    check_equal(instr.rdata[15:0], lo, "low parcel");
    if (lo[1:0] == 2'b11) begin
      check_equal(instr.rdata[31:16], parcel_at(exp_addr + 2), "high parcel");
      if (exp_addr[3:0] == 4'he) begin
        crossings++;
      end
      exp_addr = exp_addr + 4;
    end else begin
      exp_addr = exp_addr + 2;
    end
    accepted++;
  endtask

  task automatic watch_memory();
    if (req_waiting) begin
      check_equal(mem_req.req, 1'b1, "request dropped before grant");
      check_equal(mem_req.addr, req_addr, "request address changed before grant");
    end
    req_waiting = mem_req.req && !gnt;
    req_addr    = mem_req.addr;
    if (mem_rsp.rvalid) begin
      check_equal(outstanding != 0, 1'b1, "response without a grant");
      outstanding--;
    end
    if (mem_req.req && gnt) begin
      outstanding++;
    end
    check_equal(outstanding <= 1, 1'b1, "more than one grant without response");
  endtask

  ////////////////////////////////////////////////////////////////////////
  // checks on the sampling edge
  ////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      cycle++;
      if (branch && outstanding != 0 && !mem_rsp.rvalid) begin
        flushed_busy++;
      end
      watch_memory();
      if (req_expected) begin
        check_equal(mem_req.req, 1'b1, "no memory request after branch");
        check_equal(mem_req.addr, req_line, "first request address after branch");
        req_expected = 1'b0;
      end
      if (hold_pending && !branch) begin
        check_equal(valid, 1'b1, "valid_o dropped under back-pressure");
        check_equal(instr.addr, hold_pkt.addr, "address changed under back-pressure");
        check_equal(instr.rdata, hold_pkt.rdata, "data changed under back-pressure");
      end
      hold_pending = valid && !ready;
      hold_pkt     = instr;
      if (wait_first && valid) begin
        check_equal(cycle - branch_cycle >= 3, 1'b1, "valid_o too soon after branch");
        wait_first = 1'b0;
      end
      if (branch) begin
        exp_addr     = branch_addr;
        started      = 1'b1;
        wait_first   = 1'b1;
        branch_cycle = cycle;
        // an idle memory port restarts at the branch line right away
        req_expected = (outstanding == 0) && !req_waiting;
        req_line     = branch_addr & 32'hffff_fff0;
      end else if (valid && ready) begin
        score_instr();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // stimulus on the falling edge
  ////////////////////////////////////////////////////////////////////////

  task automatic run_until(input int target, input bit random_mode);
    int idle;
    int last;
    idle = 0;
    last = accepted;
    while (accepted < target) begin
      @(negedge clk);
      if (accepted != last) begin
        idle = 0;
        last = accepted;
      end else begin
        idle++;
      end
      if (idle > max_idle) begin
        $display("Timeout: no instruction accepted within %0d cycles", max_idle);
        stop_with_failure();
      end
      if (random_mode) begin
        ready = $urandom_range(0, 1);
        // single cycle pulses only
        if (!branch && $urandom_range(0, 39) == 0) begin
          branch_addr = random_addr();
          branch      = 1'b1;
        end else begin
          branch = 1'b0;
        end
      end else begin
        ready  = 1'b1;
        branch = 1'b0;
      end
    end
  endtask

  initial begin
    void'($urandom(32'hb440c61c));
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    ready       = 1'b0;
    imem.fill_random();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // no start address yet
    repeat (20) begin
      @(posedge clk);
      check_equal(valid, 1'b0, "valid_o before the first branch");
      check_equal(mem_req.req, 1'b0, "memory request before the first branch");
    end

    @(negedge clk);
    ready       = 1'b1;
    branch_addr = random_addr();
    branch      = 1'b1;
    run_until(seq_instr, 1'b0);
    run_until(total_instr, 1'b1);

    if (crossings == 0) begin
      $display("No instruction crossed a line boundary");
      stop_with_failure();
    end else if (flushed_busy == 0) begin
      $display("No branch arrived while a response was outstanding");
      stop_with_failure();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// ==== compile.f ====
design/prefetch_pkg.sv
design/line_fetcher.sv
design/instr_aligner.sv
design/prefetch_buffer.sv
bench/imem_model.sv
bench/prefetch_tb.sv

// ==== Bender.yml ====
package:
  name: prefetch_buffer

sources:
  - files:
      - design/prefetch_pkg.sv
      - design/line_fetcher.sv
      - design/instr_aligner.sv
      - design/prefetch_buffer.sv
  - target: test
    files:
      - bench/imem_model.sv
      - bench/prefetch_tb.sv
